// ==== include/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data path and address width.
`define WORD_SIZE 16

// register file size and index width.
`define NUM_REGS 4
`define REG_BITS 2

// depth of the external instruction and data memories.
`define MEM_WORDS 256

`endif

// ==== logic/cpu_pkg.sv ====
`default_nettype none

// the 16-bit instruction puts the opcode in [15:12], rs in [11:10] and rt in [9:8].
// a register type adds rd in [7:6] and the function code in [5:0].
// an immediate type holds a signed immediate in [7:0] and writes rt.
// a jump carries a target in [11:0] that replaces the low 12 bits of the next pc.
package cpu_pkg;

    typedef enum logic [3:0] {
        OP_ADI   = 4'd4,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_LHI = 3'd4 // immediate moved to the upper byte.
    } alu_op_e;

endpackage

`default_nettype wire

// ==== logic/id_ex_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

interface id_ex_bus;

    logic [`WORD_SIZE-1:0] pc;
    logic [`WORD_SIZE-1:0] rs_data;
    logic [`WORD_SIZE-1:0] rt_data;
    logic [`WORD_SIZE-1:0] imm;
    logic [`REG_BITS-1:0]  dest;
    cpu_pkg::alu_op_e      alu_op;
    logic                  alu_src_imm;
    logic                  mem_read;
    logic                  mem_write;
    logic                  reg_write;
    logic                  mem_to_reg;
    logic                  is_wwd;
    logic                  is_halt;

    modport producer (
        output pc, rs_data, rt_data, imm,
        output dest, alu_op, alu_src_imm,
        output mem_read, mem_write, reg_write, mem_to_reg,
        output is_wwd, is_halt
    );

    modport consumer (
        input pc, rs_data, rt_data, imm,
        input dest, alu_op, alu_src_imm,
        input mem_read, mem_write, reg_write, mem_to_reg,
        input is_wwd, is_halt
    );

endinterface

`default_nettype wire

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module fetch_stage (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire logic                  stall,
    input  wire logic                  jump,
    input  wire logic [`WORD_SIZE-1:0] jump_target,
    output logic      [`WORD_SIZE-1:0] i_addr,
    input  wire logic [`WORD_SIZE-1:0] i_data,
    output logic      [`WORD_SIZE-1:0] instr,
    output logic                       instr_valid,
    output logic      [`WORD_SIZE-1:0] pc_next
);

    logic [`WORD_SIZE-1:0] pc;

    assign i_addr = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc          <= '0;
            instr_valid <= 1'b0;
        end else if (jump) begin
            pc          <= jump_target;
            instr_valid <= 1'b0; // the wrong-path instruction is dropped.
        end else if (!stall) begin
            pc          <= pc + `WORD_SIZE'd1;
            instr_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !jump) begin
            instr   <= i_data;
            pc_next <= pc + `WORD_SIZE'd1;
        end
    end

    // decode only jumps on an instruction that reads no register.
    a_no_jump_and_stall: assert property (@(posedge clk) disable iff (reset_n)
        !(jump && stall));

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module decode_stage (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire logic [`WORD_SIZE-1:0] instr,
    input  wire logic                  instr_valid,
    input  wire logic [`WORD_SIZE-1:0] pc_next,
    input  wire logic [`REG_BITS-1:0]  ex_dest,
    input  wire logic                  ex_reg_write,
    input  wire logic                  wb_en,
    input  wire logic [`REG_BITS-1:0]  wb_dest,
    input  wire logic [`WORD_SIZE-1:0] wb_data,
    output logic                       stall,
    output logic                       jump,
    output logic      [`WORD_SIZE-1:0] jump_target,
    id_ex_bus.producer                 decode_bus
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];
    cpu_pkg::opcode_e      opcode;
    cpu_pkg::func_e        func;
    logic [`REG_BITS-1:0]  rs;
    logic [`REG_BITS-1:0]  rt;
    logic [`REG_BITS-1:0]  rd;
    logic                  uses_rs;
    logic                  uses_rt;
    logic                  issue;
    logic                  c_alu_src_imm;
    logic                  c_mem_read;
    logic                  c_mem_write;
    logic                  c_reg_write;
    logic                  c_mem_to_reg;
    logic                  c_is_wwd;
    logic                  c_is_halt;
    logic                  c_jump;

    assign opcode = cpu_pkg::opcode_e'(instr[15:12]);
    assign func   = cpu_pkg::func_e'(instr[5:0]);
    assign rs     = instr[11:10];
    assign rt     = instr[9:8];
    assign rd     = instr[7:6];

    always_comb begin
        uses_rs            = 1'b0;
        uses_rt            = 1'b0;
        c_alu_src_imm      = 1'b1;
        c_mem_read         = 1'b0;
        c_mem_write        = 1'b0;
        c_reg_write        = 1'b0;
        c_mem_to_reg       = 1'b0;
        c_is_wwd           = 1'b0;
        c_is_halt          = 1'b0;
        c_jump             = 1'b0;
        decode_bus.alu_op  = cpu_pkg::ALU_ADD;
        decode_bus.dest    = rt;
        case (opcode)
            cpu_pkg::OP_RTYPE: begin
                c_alu_src_imm   = 1'b0;
                decode_bus.dest = rd;
                case (func)
                    cpu_pkg::FN_ADD: decode_bus.alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUB: decode_bus.alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND: decode_bus.alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_ORR: decode_bus.alu_op = cpu_pkg::ALU_OR;
                    default:         decode_bus.alu_op = cpu_pkg::ALU_ADD;
                endcase
                case (func)
                    cpu_pkg::FN_ADD, cpu_pkg::FN_SUB, cpu_pkg::FN_AND, cpu_pkg::FN_ORR: begin
                        uses_rs     = 1'b1;
                        uses_rt     = 1'b1;
                        c_reg_write = 1'b1;
                    end
                    cpu_pkg::FN_WWD: begin
                        uses_rs  = 1'b1;
                        c_is_wwd = 1'b1;
                    end
                    cpu_pkg::FN_HLT: c_is_halt = 1'b1;
                    default: ;
                endcase
            end
            cpu_pkg::OP_ADI: begin
                uses_rs     = 1'b1;
                c_reg_write = 1'b1;
            end
            cpu_pkg::OP_LHI: begin
                decode_bus.alu_op = cpu_pkg::ALU_LHI;
                c_reg_write       = 1'b1;
            end
            cpu_pkg::OP_LWD: begin
                uses_rs      = 1'b1;
                c_mem_read   = 1'b1;
                c_reg_write  = 1'b1;
                c_mem_to_reg = 1'b1;
            end
            cpu_pkg::OP_SWD: begin
                uses_rs     = 1'b1;
                uses_rt     = 1'b1; // store data.
                c_mem_write = 1'b1;
            end
            cpu_pkg::OP_JMP: c_jump = 1'b1;
            default: ;
        endcase
    end

    // the instruction ahead of us has not reached the write-back register yet.
    assign stall = instr_valid && ex_reg_write &&
                   ((uses_rs && rs == ex_dest) || (uses_rt && rt == ex_dest));
    assign jump        = instr_valid && c_jump;
    assign jump_target = {pc_next[`WORD_SIZE-1:12], instr[11:0]};
    assign issue       = instr_valid && !stall;

    assign decode_bus.pc          = pc_next;
    assign decode_bus.imm         = {{(`WORD_SIZE-8){instr[7]}}, instr[7:0]};
    assign decode_bus.alu_src_imm = issue && c_alu_src_imm;
    assign decode_bus.mem_read    = issue && c_mem_read;
    assign decode_bus.mem_write   = issue && c_mem_write;
    assign decode_bus.reg_write   = issue && c_reg_write;
    assign decode_bus.mem_to_reg  = issue && c_mem_to_reg;
    assign decode_bus.is_wwd      = issue && c_is_wwd;
    assign decode_bus.is_halt     = issue && c_is_halt;

    // write-first read, so the instruction in write-back needs no stall.
    assign decode_bus.rs_data = (wb_en && wb_dest == rs) ? wb_data : regs[rs];
    assign decode_bus.rt_data = (wb_en && wb_dest == rt) ? wb_data : regs[rt];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_dest] <= wb_data;
        end
    end

    a_single_mem_access: assert property (@(posedge clk) disable iff (reset_n)
        !(decode_bus.mem_read && decode_bus.mem_write));

endmodule

`default_nettype wire

// ==== logic/id_ex.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex (
    input  wire logic  clk,
    input  wire logic  reset_n,
    id_ex_bus.consumer in_bus,
    id_ex_bus.producer out_bus
);

    // the control bits clear so that execute starts with a bubble.
    always_ff @(posedge clk) begin
        if (reset_n) begin
            out_bus.mem_read  <= 1'b0;
            out_bus.mem_write <= 1'b0;
            out_bus.reg_write <= 1'b0;
            out_bus.is_wwd    <= 1'b0;
            out_bus.is_halt   <= 1'b0;
        end else begin
            out_bus.mem_read  <= in_bus.mem_read;
            out_bus.mem_write <= in_bus.mem_write;
            out_bus.reg_write <= in_bus.reg_write;
            out_bus.is_wwd    <= in_bus.is_wwd;
            out_bus.is_halt   <= in_bus.is_halt;
        end
    end

    always_ff @(posedge clk) begin
        out_bus.pc          <= in_bus.pc;
        out_bus.rs_data     <= in_bus.rs_data;
        out_bus.rt_data     <= in_bus.rt_data;
        out_bus.imm         <= in_bus.imm;
        out_bus.dest        <= in_bus.dest;
        out_bus.alu_op      <= in_bus.alu_op;
        out_bus.alu_src_imm <= in_bus.alu_src_imm;
        out_bus.mem_to_reg  <= in_bus.mem_to_reg; // selects the loaded word for write-back.
    end

endmodule

`default_nettype wire

// ==== logic/execute_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module execute_wb (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    id_ex_bus.consumer                 exec_bus,
    output logic      [`WORD_SIZE-1:0] d_addr,
    output logic                       d_read,
    output logic                       d_write,
    output logic      [`WORD_SIZE-1:0] d_wdata,
    input  wire logic [`WORD_SIZE-1:0] d_rdata,
    output logic                       wb_en,
    output logic      [`REG_BITS-1:0]  wb_dest,
    output logic      [`WORD_SIZE-1:0] wb_data,
    output logic      [`WORD_SIZE-1:0] output_port,
    output logic                       output_valid,
    output logic                       is_halted
);

    logic [`WORD_SIZE-1:0] operand_b;
    logic [`WORD_SIZE-1:0] alu_result;

    assign operand_b = exec_bus.alu_src_imm ? exec_bus.imm : exec_bus.rt_data;

    always_comb begin
        case (exec_bus.alu_op)
            cpu_pkg::ALU_ADD: alu_result = exec_bus.rs_data + operand_b;
            cpu_pkg::ALU_SUB: alu_result = exec_bus.rs_data - operand_b;
            cpu_pkg::ALU_AND: alu_result = exec_bus.rs_data & operand_b;
            cpu_pkg::ALU_OR:  alu_result = exec_bus.rs_data | operand_b;
            cpu_pkg::ALU_LHI: alu_result = {operand_b[7:0], 8'h00};
            default:          alu_result = '0;
        endcase
    end

    // loads and stores address memory with rs plus the immediate.
    assign d_addr  = alu_result;
    assign d_wdata = exec_bus.rt_data;
    assign d_read  = exec_bus.mem_read && !is_halted;
    assign d_write = exec_bus.mem_write && !is_halted;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            wb_en        <= 1'b0;
            output_valid <= 1'b0;
            is_halted    <= 1'b0;
        end else begin
            wb_en        <= exec_bus.reg_write && !is_halted;
            output_valid <= exec_bus.is_wwd && !is_halted;
            if (exec_bus.is_halt) begin
                is_halted <= 1'b1; // sticky until the next reset.
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_dest <= exec_bus.dest;
        wb_data <= exec_bus.mem_to_reg ? d_rdata : alu_result;
        if (exec_bus.is_wwd) begin
            output_port <= exec_bus.rs_data;
        end
    end

    a_no_read_and_write: assert property (@(posedge clk) disable iff (reset_n)
        !(d_read && d_write));

    // a memory access comes from an instruction inside instruction memory and stays in range.
    a_mem_in_range: assert property (@(posedge clk) disable iff (reset_n)
        (d_read || d_write) |-> (d_addr < `MEM_WORDS && exec_bus.pc <= `MEM_WORDS));

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_core (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    output logic      [`WORD_SIZE-1:0] i_addr,
    input  wire logic [`WORD_SIZE-1:0] i_data,
    output logic      [`WORD_SIZE-1:0] d_addr,
    output logic                       d_read,
    output logic                       d_write,
    output logic      [`WORD_SIZE-1:0] d_wdata,
    input  wire logic [`WORD_SIZE-1:0] d_rdata,
    output logic      [`WORD_SIZE-1:0] output_port,
    output logic                       output_valid,
    output logic                       is_halted
);

    logic                  stall;
    logic                  jump;
    logic [`WORD_SIZE-1:0] jump_target;
    logic [`WORD_SIZE-1:0] instr;
    logic                  instr_valid;
    logic [`WORD_SIZE-1:0] pc_next;
    logic                  wb_en;
    logic [`REG_BITS-1:0]  wb_dest;
    logic [`WORD_SIZE-1:0] wb_data;

    id_ex_bus decode_bus ();
    id_ex_bus execute_bus ();

    fetch_stage u_fetch (
        .clk         (clk),
        .reset_n     (reset_n),
        .stall       (stall),
        .jump        (jump),
        .jump_target (jump_target),
        .i_addr      (i_addr),
        .i_data      (i_data),
        .instr       (instr),
        .instr_valid (instr_valid),
        .pc_next     (pc_next)
    );

    decode_stage u_decode (
        .clk          (clk),
        .reset_n      (reset_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .pc_next      (pc_next),
        .ex_dest      (execute_bus.dest), // hazard check against execute.
        .ex_reg_write (execute_bus.reg_write),
        .wb_en        (wb_en),
        .wb_dest      (wb_dest),
        .wb_data      (wb_data),
        .stall        (stall),
        .jump         (jump),
        .jump_target  (jump_target),
        .decode_bus   (decode_bus.producer)
    );

    id_ex u_id_ex (
        .clk     (clk),
        .reset_n (reset_n),
        .in_bus  (decode_bus.consumer),
        .out_bus (execute_bus.producer)
    );

    execute_wb u_execute (
        .clk          (clk),
        .reset_n      (reset_n),
        .exec_bus     (execute_bus.consumer),
        .d_addr       (d_addr),
        .d_read       (d_read),
        .d_write      (d_write),
        .d_wdata      (d_wdata),
        .d_rdata      (d_rdata),
        .wb_en        (wb_en),
        .wb_dest      (wb_dest),
        .wb_data      (wb_data),
        .output_port  (output_port),
        .output_valid (output_valid),
        .is_halted    (is_halted)
    );

endmodule

`default_nettype wire

// ==== dv/cpu_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_core_tb;

    localparam int NUM_TESTS    = 6;
    localparam int CYCLE_LIMIT  = NUM_TESTS * 200;
    localparam int DRAIN_CYCLES = 8;
    localparam int MODEL_STEPS  = 200;

    logic                  clk = 1'b0;
    logic                  reset_n;
    logic [`WORD_SIZE-1:0] i_addr;
    logic [`WORD_SIZE-1:0] i_data;
    logic [`WORD_SIZE-1:0] d_addr;
    logic                  d_read;
    logic                  d_write;
    logic [`WORD_SIZE-1:0] d_wdata;
    logic [`WORD_SIZE-1:0] d_rdata;
    logic [`WORD_SIZE-1:0] output_port;
    logic                  output_valid;
    logic                  is_halted;

    logic [`WORD_SIZE-1:0] imem [`MEM_WORDS];
    logic [`WORD_SIZE-1:0] dmem [`MEM_WORDS];
    logic [`WORD_SIZE-1:0] exp_out [$];
    logic [`WORD_SIZE-1:0] exp_waddr [$];
    logic [`WORD_SIZE-1:0] exp_wdata [$];
    logic [`WORD_SIZE-1:0] exp_raddr [$];
    logic [`WORD_SIZE-1:0] got_out [$];
    logic [`WORD_SIZE-1:0] got_waddr [$];
    logic [`WORD_SIZE-1:0] got_wdata [$];
    logic [`WORD_SIZE-1:0] got_raddr [$];
    logic                  exp_halt;
    int                    prog_len;
    int                    checks = 0;
    int                    errors = 0;
    int                    cycle_count = 0;
    integer                seed = 32'hf003_37d1;

    cpu_core dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_addr       (i_addr),
        .i_data       (i_data),
        .d_addr       (d_addr),
        .d_read       (d_read),
        .d_write      (d_write),
        .d_wdata      (d_wdata),
        .d_rdata      (d_rdata),
        .output_port  (output_port),
        .output_valid (output_valid),
        .is_halted    (is_halted)
    );

    always #50 clk = ~clk;

    // both memories answer combinationally and data writes land on the rising edge.
    assign i_data  = (i_addr < `MEM_WORDS) ? imem[i_addr] : '0;
    assign d_rdata = (d_addr < `MEM_WORDS) ? dmem[d_addr] : '0;

    always @(posedge clk) begin
        if (d_write && d_addr < `MEM_WORDS) begin
            dmem[d_addr] <= d_wdata;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [`WORD_SIZE-1:0] rtype(input cpu_pkg::func_e fn,
            input logic [1:0] rs, input logic [1:0] rt, input logic [1:0] rd);
        return {cpu_pkg::OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic logic [`WORD_SIZE-1:0] itype(input cpu_pkg::opcode_e op,
            input logic [1:0] rs, input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [`WORD_SIZE-1:0] jmp_to(input logic [11:0] target);
        return {cpu_pkg::OP_JMP, target};
    endfunction

    function automatic logic [`WORD_SIZE-1:0] wwd(input logic [1:0] rs);
        return rtype(cpu_pkg::FN_WWD, rs, 2'd0, 2'd0);
    endfunction

    task automatic check_value(input string name, input logic [`WORD_SIZE-1:0] got,
            input logic [`WORD_SIZE-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // opcode zero decodes to nothing, so empty memory acts as a nop sled.
    task automatic clear_memories();
        prog_len = 0;
        for (int a = 0; a < `MEM_WORDS; a++) begin
            imem[a] = '0;
            dmem[a] = (`WORD_SIZE'(a) * `WORD_SIZE'h9e37) ^ `WORD_SIZE'h5a5a;
        end
    endtask

    task automatic append_instr(input logic [`WORD_SIZE-1:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_n = 1'b1;
        repeat (5) @(negedge clk);
        reset_n = 1'b0;
    endtask

    // sequential ISA model that runs one instruction per step on a copy of data memory.
    task automatic reference_run();
        logic [`WORD_SIZE-1:0] r [`NUM_REGS];
        logic [`WORD_SIZE-1:0] mem [`MEM_WORDS];
        logic [`WORD_SIZE-1:0] pc;
        logic [`WORD_SIZE-1:0] ins;
        logic [`WORD_SIZE-1:0] imm;
        logic [`WORD_SIZE-1:0] addr;
        logic [`REG_BITS-1:0]  rs;
        logic [`REG_BITS-1:0]  rt;
        logic [`REG_BITS-1:0]  rd;
        int                    steps;
        exp_out.delete();
        exp_waddr.delete();
        exp_wdata.delete();
        exp_raddr.delete();
        exp_halt = 1'b0;
        pc = '0;
        steps = 0;
        foreach (r[i]) begin
            r[i] = '0;
        end
        mem = dmem;
        while (!exp_halt && steps < MODEL_STEPS) begin
            ins  = (pc < `MEM_WORDS) ? imem[pc] : '0;
            rs   = ins[11:10];
            rt   = ins[9:8];
            rd   = ins[7:6];
            imm  = {{(`WORD_SIZE-8){ins[7]}}, ins[7:0]};
            addr = r[rs] + imm;
            pc   = pc + 1'b1;
            case (ins[15:12])
                cpu_pkg::OP_ADI: r[rt] = r[rs] + imm;
                cpu_pkg::OP_LHI: r[rt] = {ins[7:0], 8'h00};
                cpu_pkg::OP_LWD: begin
                    r[rt] = mem[addr];
                    exp_raddr.push_back(addr);
                end
                cpu_pkg::OP_SWD: begin
                    mem[addr] = r[rt];
                    exp_waddr.push_back(addr);
                    exp_wdata.push_back(r[rt]);
                end
                cpu_pkg::OP_JMP: pc = {pc[`WORD_SIZE-1:12], ins[11:0]}; // pc is already pc + 1.
                cpu_pkg::OP_RTYPE: begin
                    case (ins[5:0])
                        cpu_pkg::FN_ADD: r[rd] = r[rs] + r[rt];
                        cpu_pkg::FN_SUB: r[rd] = r[rs] - r[rt];
                        cpu_pkg::FN_AND: r[rd] = r[rs] & r[rt];
                        cpu_pkg::FN_ORR: r[rd] = r[rs] | r[rt];
                        cpu_pkg::FN_WWD: exp_out.push_back(r[rs]);
                        cpu_pkg::FN_HLT: exp_halt = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
            steps++;
        end
    endtask

    task automatic sample_outputs();
        if (output_valid) begin
            got_out.push_back(output_port);
        end
        if (d_write) begin
            got_waddr.push_back(d_addr);
            got_wdata.push_back(d_wdata);
        end
        if (d_read) begin
            got_raddr.push_back(d_addr);
        end
    endtask

    task automatic compare_results();
        checks++;
        assert (got_out.size() == exp_out.size()) else begin
            errors++;
            $display("wrong number of output words: saw %0d, expected %0d",
                     got_out.size(), exp_out.size());
        end
        checks++;
        assert (got_waddr.size() == exp_waddr.size()) else begin
            errors++;
            $display("wrong number of data memory writes: saw %0d, expected %0d",
                     got_waddr.size(), exp_waddr.size());
        end
        checks++;
        assert (got_raddr.size() == exp_raddr.size()) else begin
            errors++;
            $display("wrong number of data memory reads: saw %0d, expected %0d",
                     got_raddr.size(), exp_raddr.size());
        end
        for (int i = 0; i < got_out.size() && i < exp_out.size(); i++) begin
            check_value("output_port", got_out[i], exp_out[i]);
        end
        for (int i = 0; i < got_waddr.size() && i < exp_waddr.size(); i++) begin
            check_value("d_addr", got_waddr[i], exp_waddr[i]);
            check_value("d_wdata", got_wdata[i], exp_wdata[i]);
        end
        for (int i = 0; i < got_raddr.size() && i < exp_raddr.size(); i++) begin
            check_value("d_addr", got_raddr[i], exp_raddr[i]);
        end
    endtask

    // runs the loaded program until is_halted, then watches a few more cycles.
    task automatic run_program();
        reference_run();
        got_out.delete();
        got_waddr.delete();
        got_wdata.delete();
        got_raddr.delete();
        apply_reset();
        while (is_halted !== 1'b1) begin
            @(negedge clk);
            sample_outputs();
        end
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            sample_outputs();
            check_value("is_halted", is_halted, exp_halt);
        end
        compare_results();
    endtask

    task automatic reset_values();
        clear_memories();
        apply_reset();
        check_value("i_addr", i_addr, '0);
        check_value("d_read", d_read, 1'b0);
        check_value("d_write", d_write, 1'b0);
        check_value("output_valid", output_valid, 1'b0);
        check_value("is_halted", is_halted, 1'b0);
    endtask

    task automatic arith_chain();
        clear_memories();
        append_instr(itype(cpu_pkg::OP_LHI, 2'd0, 2'd1, 8'h12));
        append_instr(itype(cpu_pkg::OP_ADI, 2'd1, 2'd1, 8'h34));
        append_instr(wwd(2'd1));
        append_instr(itype(cpu_pkg::OP_LHI, 2'd0, 2'd2, 8'h0f));
        append_instr(itype(cpu_pkg::OP_ADI, 2'd2, 2'd2, 8'hff)); // negative immediate.
        append_instr(rtype(cpu_pkg::FN_ADD, 2'd1, 2'd2, 2'd3));
        append_instr(wwd(2'd3));
        append_instr(rtype(cpu_pkg::FN_SUB, 2'd3, 2'd1, 2'd0));
        append_instr(wwd(2'd0));
        append_instr(rtype(cpu_pkg::FN_AND, 2'd3, 2'd2, 2'd1));
        append_instr(wwd(2'd1));
        append_instr(rtype(cpu_pkg::FN_ORR, 2'd1, 2'd3, 2'd2));
        append_instr(wwd(2'd2));
        append_instr(rtype(cpu_pkg::FN_HLT, 2'd0, 2'd0, 2'd0));
        run_program();
    endtask

    task automatic load_store();
        clear_memories();
        append_instr(itype(cpu_pkg::OP_ADI, 2'd0, 2'd0, 8'h20));
        append_instr(itype(cpu_pkg::OP_LHI, 2'd0, 2'd1, 8'hab));
        append_instr(itype(cpu_pkg::OP_ADI, 2'd1, 2'd1, 8'h55));
        append_instr(itype(cpu_pkg::OP_SWD, 2'd0, 2'd1, 8'h05));
        append_instr(itype(cpu_pkg::OP_LWD, 2'd0, 2'd2, 8'h05));
        append_instr(rtype(cpu_pkg::FN_ADD, 2'd2, 2'd1, 2'd3));
        append_instr(wwd(2'd3));
        append_instr(itype(cpu_pkg::OP_LWD, 2'd0, 2'd2, 8'hfd)); // reads the fill pattern.
        append_instr(wwd(2'd2));
        append_instr(rtype(cpu_pkg::FN_HLT, 2'd0, 2'd0, 2'd0));
        run_program();
    endtask

    task automatic jump_over();
        clear_memories();
        append_instr(itype(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'h11));
        append_instr(jmp_to(12'd4));
        append_instr(itype(cpu_pkg::OP_ADI, 2'd1, 2'd1, 8'h40));
        append_instr(wwd(2'd1));
        append_instr(wwd(2'd1));
        append_instr(jmp_to(12'd8));
        append_instr(wwd(2'd1));
        append_instr(wwd(2'd1));
        append_instr(itype(cpu_pkg::OP_ADI, 2'd1, 2'd1, 8'h01));
        append_instr(wwd(2'd1));
        append_instr(rtype(cpu_pkg::FN_HLT, 2'd0, 2'd0, 2'd0));
        run_program();
    endtask

    task automatic halt_blocks();
        clear_memories();
        append_instr(itype(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'h2a));
        append_instr(wwd(2'd1));
        append_instr(rtype(cpu_pkg::FN_HLT, 2'd0, 2'd0, 2'd0));
        append_instr(itype(cpu_pkg::OP_SWD, 2'd0, 2'd1, 8'h10));
        append_instr(wwd(2'd1));
        append_instr(itype(cpu_pkg::OP_ADI, 2'd1, 2'd1, 8'h01));
        append_instr(wwd(2'd1));
        run_program();
    endtask

    task automatic random_imm();
        logic [7:0]  imm [6];
        logic [31:0] rnd;
        foreach (imm[i]) begin
            rnd    = $random(seed);
            imm[i] = rnd[7:0];
        end
        clear_memories();
        append_instr(itype(cpu_pkg::OP_LHI, 2'd0, 2'd0, imm[0]));
        append_instr(itype(cpu_pkg::OP_ADI, 2'd0, 2'd0, imm[1]));
        append_instr(wwd(2'd0));
        append_instr(itype(cpu_pkg::OP_LHI, 2'd0, 2'd1, imm[2]));
        append_instr(itype(cpu_pkg::OP_ADI, 2'd1, 2'd1, imm[3]));
        append_instr(wwd(2'd1));
        append_instr(rtype(cpu_pkg::FN_ADD, 2'd0, 2'd1, 2'd2));
        append_instr(wwd(2'd2));
        append_instr(rtype(cpu_pkg::FN_SUB, 2'd0, 2'd1, 2'd3));
        append_instr(wwd(2'd3));
        append_instr(itype(cpu_pkg::OP_ADI, 2'd2, 2'd2, imm[4]));
        append_instr(rtype(cpu_pkg::FN_ORR, 2'd3, 2'd2, 2'd3));
        append_instr(wwd(2'd3));
        append_instr(itype(cpu_pkg::OP_LHI, 2'd0, 2'd1, imm[5]));
        append_instr(rtype(cpu_pkg::FN_AND, 2'd3, 2'd1, 2'd0));
        append_instr(wwd(2'd0));
        append_instr(rtype(cpu_pkg::FN_HLT, 2'd0, 2'd0, 2'd0));
        run_program();
    endtask

    initial begin
        reset_n = 1'b1;
        reset_values();
        arith_chain();
        load_store();
        jump_over();
        halt_blocks();
        random_imm();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
logic/cpu_pkg.sv
logic/id_ex_bus.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/id_ex.sv
logic/execute_wb.sv
logic/cpu_core.sv
dv/cpu_core_tb.sv
